// ==== logic/sdramPkg.sv ====
`default_nettype none

package sdramPkg;

  localparam int bankWidth        = 2;
  localparam int rowWidth         = 13;
  localparam int columnWidth      = 9;  // Bit 0 picks the 16-bit half of a word.
  localparam int wordAddressWidth = bankWidth + rowWidth + columnWidth - 1;

  // Encoded as {csN, rasN, casN, weN}.
  typedef enum logic [3:0] {
    cmdInhibit   = 4'b1111,
    cmdNop       = 4'b0111,
    cmdActive    = 4'b0011,
    cmdRead      = 4'b0101,
    cmdWrite     = 4'b0100,
    cmdPrecharge = 4'b0010,
    cmdRefresh   = 4'b0001,
    cmdLoadMode  = 4'b0000
  } sdramCommandT;

  // Single write burst, CAS latency 2, sequential, burst length 1.
  localparam logic [14:0] modeRegisterValue         = 15'b00_000_1_00_010_0_000;
  localparam logic [14:0] extendedModeRegisterValue = 15'b100000001000000;

  localparam int casLatency            = 2;
  localparam int readWaitCycles        = casLatency + 1;  // Includes the pin register.
  localparam int refreshRecoveryCycles = 8;                // Covers tRFC up to 100 MHz.
  localparam int powerUpDivider        = 10000;            // 100 us is 1/10000 s.
  localparam int refreshPeriodDivider  = 128000;           // 7.8125 us is 1/128000 s.
  localparam int refreshSlackCycles    = 16;  // Room for a request still in flight.

  typedef struct packed {
    logic                        valid;
    logic                        readNotWrite;
    logic [wordAddressWidth-1:0] address;
    logic [3:0]                  byteEnables;
    logic [31:0]                 writeData;
  } busRequestT;

  typedef struct packed {
    logic        done;
    logic [31:0] readData;
  } busResponseT;

  typedef struct packed {
    sdramCommandT          command;
    logic [bankWidth-1:0]  bank;
    logic [rowWidth-1:0]   address;
    logic [1:0]            dqmN;
    logic [15:0]           dataOut;
    logic                  dataDriven;
  } sdramPinsT;

  typedef enum logic [4:0] {
    resetState, waitPowerUp,
    prechargeAll, waitPrechargeAll,
    refreshInit1, waitRefreshInit1, refreshInit2, waitRefreshInit2,
    loadMode, waitLoadMode, loadExtendedMode,
    idle,
    refresh, waitRefresh,
    activate, waitActivate,
    writeLo, writeHi,
    readLo, readHi, waitReadData,
    precharge, waitPrecharge
  } sequencerStateT;

endpackage

`default_nettype wire

// ==== logic/sdramTimer.sv ====
`default_nettype none

module sdramTimer
  import sdramPkg::*;
#(
  parameter int clockInHz = 10000000
)
(
  input  logic clock,
  input  logic reset,
  input  logic refreshIssued,
  output logic powerUpDone,
  output logic refreshDue
);

  localparam int powerUpCount = clockInHz / powerUpDivider;
  localparam int refreshCount = clockInHz / refreshPeriodDivider - refreshSlackCycles;
  localparam int powerUpWidth = $clog2(powerUpCount + 1);
  localparam int refreshWidth = $clog2(refreshCount + 1);

  logic [powerUpWidth-1:0] powerUpCounter;
  logic [refreshWidth-1:0] refreshCounter;

  assign powerUpDone = (powerUpCounter == '0);  // Counter parks at zero.

  always_ff @(posedge clock)
  begin
    if (reset)
      powerUpCounter <= powerUpWidth'(powerUpCount - 1);
    else if (!powerUpDone)
      powerUpCounter <= powerUpCounter - 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (reset || refreshIssued)
    begin
      refreshCounter <= refreshWidth'(refreshCount - 1);
      refreshDue     <= 1'b0;
    end
    else if (refreshCounter != '0)
    begin
      refreshCounter <= refreshCounter - 1'b1;
    end
    else
    begin
      refreshDue <= 1'b1;  // Held until the sequencer issues a refresh.
    end
  end

endmodule

`default_nettype wire

// ==== logic/sdramSequencer.sv ====
`default_nettype none

module sdramSequencer
  import sdramPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  busRequestT             request,
  input  logic                   powerUpDone,
  input  logic                   refreshDue,
  input  logic [15:0]            sdramDataIn,
  output logic                   refreshIssued,
  output logic                   ready,
  output logic                   initBusy,
  output busResponseT            response,
  output sequencerStateT         state,
  output logic [bankWidth-1:0]   bank,
  output logic [rowWidth-1:0]    row,
  output logic [columnWidth-1:0] column,
  output logic [3:0]             byteEnables,
  output logic [31:0]            writeData
);

  localparam int delayWidth = $clog2(refreshRecoveryCycles + readWaitCycles);

  sequencerStateT            nextState;
  logic                      accept;
  logic                      readNotWrite;
  logic [delayWidth-1:0]     delayCount;
  logic                      delayDone;
  logic [readWaitCycles-1:0] loPipe;
  logic [readWaitCycles-1:0] hiPipe;
  logic [15:0]               wordLo;
  logic [15:0]               wordHi;

  assign ready         = (state == idle) && !refreshDue;  // Refresh wins over requests.
  assign accept        = ready && request.valid;
  assign delayDone     = (delayCount == '0);
  assign refreshIssued = (state == refreshInit1) || (state == refreshInit2) ||
                         (state == refresh);

  assign response.done     = (state == waitPrecharge);
  assign response.readData = ((state == waitPrecharge) && readNotWrite) ?
                             {wordHi, wordLo} : '0;

  always_comb
  begin
    nextState = state;
    case (state)
      resetState       : nextState = waitPowerUp;
      waitPowerUp      : nextState = powerUpDone ? prechargeAll : waitPowerUp;
      prechargeAll     : nextState = waitPrechargeAll;
      waitPrechargeAll : nextState = refreshInit1;
      refreshInit1     : nextState = waitRefreshInit1;
      waitRefreshInit1 : nextState = delayDone ? refreshInit2 : waitRefreshInit1;
      refreshInit2     : nextState = waitRefreshInit2;
      waitRefreshInit2 : nextState = delayDone ? loadMode : waitRefreshInit2;
      loadMode         : nextState = waitLoadMode;
      waitLoadMode     : nextState = loadExtendedMode;
      loadExtendedMode : nextState = idle;
      idle:
      begin
        if (refreshDue)
          nextState = refresh;
        else if (accept)
          nextState = activate;
      end
      refresh          : nextState = waitRefresh;
      waitRefresh      : nextState = delayDone ? idle : waitRefresh;
      activate         : nextState = waitActivate;
      waitActivate:
      begin
        if (readNotWrite)
          nextState = readLo;
        else if (byteEnables[1:0] != 2'b00)
          nextState = writeLo;
        else if (byteEnables[3:2] != 2'b00)
          nextState = writeHi;
        else
          nextState = precharge;  // Only the row is closed when no byte is enabled.
      end
      writeLo          : nextState = (byteEnables[3:2] != 2'b00) ? writeHi : precharge;
      writeHi          : nextState = precharge;
      readLo           : nextState = readHi;
      readHi           : nextState = waitReadData;
      waitReadData     : nextState = delayDone ? precharge : waitReadData;
      precharge        : nextState = waitPrecharge;
      waitPrecharge    : nextState = idle;
      default          : nextState = resetState;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      state <= resetState;
    else
      state <= nextState;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      initBusy <= 1'b1;
    else if (state == loadExtendedMode)
      initBusy <= 1'b0;
  end

  // Short delay for refresh recovery and the read return.
  always_ff @(posedge clock)
  begin
    if (reset)
      delayCount <= '0;
    else if (refreshIssued)
      delayCount <= delayWidth'(refreshRecoveryCycles - 1);
    else if (state == readHi)
      delayCount <= delayWidth'(readWaitCycles - 1);
    else if (!delayDone)
      delayCount <= delayCount - 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      readNotWrite <= request.readNotWrite;
      bank         <= request.address[wordAddressWidth-1 -: bankWidth];
      row          <= request.address[columnWidth-1 +: rowWidth];
      column       <= {request.address[columnWidth-2:0], 1'b0};
      byteEnables  <= request.byteEnables;
      writeData    <= request.writeData;
    end
  end

  // Read markers follow the command through the pin register and CAS latency.
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      loPipe <= '0;
      hiPipe <= '0;
    end
    else
    begin
      loPipe <= {loPipe[readWaitCycles-2:0], state == readLo};
      hiPipe <= {hiPipe[readWaitCycles-2:0], state == readHi};
    end
  end

  always_ff @(posedge clock)
  begin
    if (loPipe[readWaitCycles-1])
      wordLo <= sdramDataIn;
    if (hiPipe[readWaitCycles-1])
      wordHi <= sdramDataIn;
  end

endmodule

`default_nettype wire

// ==== logic/sdramCommandOut.sv ====
`default_nettype none

module sdramCommandOut
  import sdramPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  sequencerStateT         state,
  input  logic [bankWidth-1:0]   bank,
  input  logic [rowWidth-1:0]    row,
  input  logic [columnWidth-1:0] column,
  input  logic [3:0]             byteEnables,
  input  logic [31:0]            writeData,
  output sdramPinsT              pins
);

  sdramPinsT            pinsNext;
  logic                 highHalf;
  logic [rowWidth-1:0]  columnAddress;

  assign highHalf      = (state == writeHi) || (state == readHi);
  assign columnAddress = {{(rowWidth - columnWidth){1'b0}},
                          column[columnWidth-1:1], highHalf};

  always_comb
  begin
    pinsNext            = '0;
    pinsNext.command    = cmdNop;
    pinsNext.dqmN       = 2'b11;
    pinsNext.dataOut    = highHalf ? writeData[31:16] : writeData[15:0];
    case (state)
      resetState, waitPowerUp:
        pinsNext.command = cmdInhibit;
      prechargeAll, precharge:
      begin
        pinsNext.command     = cmdPrecharge;
        pinsNext.address[10] = 1'b1;  // All banks.
      end
      refreshInit1, refreshInit2, refresh:
        pinsNext.command = cmdRefresh;
      loadMode:
      begin
        pinsNext.command                    = cmdLoadMode;
        {pinsNext.bank, pinsNext.address}   = modeRegisterValue;
      end
      loadExtendedMode:
      begin
        pinsNext.command                    = cmdLoadMode;
        {pinsNext.bank, pinsNext.address}   = extendedModeRegisterValue;
      end
      activate:
      begin
        pinsNext.command = cmdActive;
        pinsNext.bank    = bank;
        pinsNext.address = row;
      end
      readLo, readHi:
      begin
        pinsNext.command = cmdRead;
        pinsNext.bank    = bank;
        pinsNext.address = columnAddress;
        pinsNext.dqmN    = 2'b00;
      end
      writeLo, writeHi:
      begin
        pinsNext.command    = cmdWrite;
        pinsNext.bank       = bank;
        pinsNext.address    = columnAddress;
        pinsNext.dqmN       = highHalf ? ~byteEnables[3:2] : ~byteEnables[1:0];
        pinsNext.dataDriven = 1'b1;
      end
      default:
        pinsNext.command = cmdNop;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pins.command    <= cmdInhibit;
      pins.dqmN       <= 2'b11;
      pins.dataDriven <= 1'b0;
    end
    else
    begin
      pins <= pinsNext;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sdramController.sv ====
`default_nettype none

module sdramController
  import sdramPkg::*;
#(
  parameter int clockInHz = 10000000
)
(
  input  logic        clock,
  input  logic        reset,
  input  busRequestT  request,
  output logic        ready,
  output busResponseT response,
  output logic        initBusy,
  output sdramPinsT   pins,
  input  logic [15:0] sdramDataIn
);

  logic                   powerUpDone;
  logic                   refreshDue;
  logic                   refreshIssued;
  sequencerStateT         state;
  logic [bankWidth-1:0]   bank;
  logic [rowWidth-1:0]    row;
  logic [columnWidth-1:0] column;
  logic [3:0]             byteEnables;
  logic [31:0]            writeData;

  sdramTimer #(
    .clockInHz(clockInHz)
  ) timer (
    .clock        (clock),
    .reset        (reset),
    .refreshIssued(refreshIssued),
    .powerUpDone  (powerUpDone),
    .refreshDue   (refreshDue)
  );

  sdramSequencer sequencer (
    .clock        (clock),
    .reset        (reset),
    .request      (request),
    .powerUpDone  (powerUpDone),
    .refreshDue   (refreshDue),
    .sdramDataIn  (sdramDataIn),
    .refreshIssued(refreshIssued),
    .ready        (ready),
    .initBusy     (initBusy),
    .response     (response),
    .state        (state),
    .bank         (bank),
    .row          (row),
    .column       (column),
    .byteEnables  (byteEnables),
    .writeData    (writeData)
  );

  sdramCommandOut commandOut (
    .clock      (clock),
    .reset      (reset),
    .state      (state),
    .bank       (bank),
    .row        (row),
    .column     (column),
    .byteEnables(byteEnables),
    .writeData  (writeData),
    .pins       (pins)
  );

endmodule

`default_nettype wire

// ==== test/sdramModel.sv ====
`default_nettype none

module sdramModel
  import sdramPkg::*;
#(
  parameter int powerUpCycles = 1000
)
(
  input  logic        clock,
  input  logic        reset,
  input  sdramPinsT   pins,
  output logic [15:0] readData,
  output int          protocolErrors,
  output int          refreshCount,
  output int          initSteps
);

  logic [15:0]         storage [bit [23:0]];  // Key is bank, row, column.
  logic [rowWidth-1:0] openRow [4];
  logic [15:0]         readStage;
  logic [15:0]         word;
  logic [23:0]         cellAddress;
  int                  cycleCount;
  int                  errors = 0;

  function automatic sdramCommandT initCommand(input int step);
    case (step)
      0       : return cmdPrecharge;
      1, 2    : return cmdRefresh;
      default : return cmdLoadMode;
    endcase
  endfunction

  task automatic reportError(input string what);
    $display("Memory model at %0t: %s", $time, what);
    errors++;
  endtask

  always @(posedge clock)
  begin
    if (reset)
    begin
      cycleCount   <= 0;
      initSteps    <= 0;
      refreshCount <= 0;
      readStage    <= '0;
      readData     <= '0;
    end
    else
    begin
      cellAddress = {pins.bank, openRow[pins.bank], pins.address[columnWidth-1:0]};
      cycleCount <= cycleCount + 1;
      readStage  <= '0;
      readData   <= readStage;  // Second stage of the CAS latency.
      if (pins.dataDriven != (pins.command == cmdWrite))
        reportError("data bus driven outside a write command");
      if (pins.command == cmdWrite && pins.dqmN == 2'b11)
        reportError("write issued for a half with no enabled bytes");
      if (initSteps < 5 && pins.command != cmdNop && pins.command != cmdInhibit)
      begin
        if (cycleCount < powerUpCycles)
          reportError("command issued during the power-up wait");
        if (pins.command != initCommand(initSteps))
          reportError("init command out of order");
        initSteps <= initSteps + 1;
      end
      case (pins.command)
        cmdActive:
          openRow[pins.bank] <= pins.address;
        cmdRefresh:
          refreshCount <= refreshCount + 1;
        cmdWrite:
        begin
          word = storage.exists(cellAddress) ? storage[cellAddress] : 16'h0000;
          if (!pins.dqmN[0])
            word[7:0] = pins.dataOut[7:0];
          if (!pins.dqmN[1])
            word[15:8] = pins.dataOut[15:8];
          storage[cellAddress] = word;
        end
        cmdRead:
          readStage <= storage.exists(cellAddress) ? storage[cellAddress] : 16'h0000;
        default:
          ;
      endcase
    end
    protocolErrors <= errors;
  end

endmodule

`default_nettype wire

// ==== test/sdramControllerTb.sv ====
`default_nettype none

module sdramControllerTb
  import sdramPkg::*;
();

  localparam int clockInHz           = 10000000;
  localparam int clockPeriod         = 20;
  localparam int powerUpCycles       = clockInHz / 10000;
  localparam int refreshPeriodCycles = clockInHz / 128000;
  localparam int plannedRequests     = 120;
  localparam int idleCycles          = 600;
  localparam int watchdogCycles      = 2 * (powerUpCycles + 200 * plannedRequests + idleCycles);
  localparam logic [23:0] enableList = 24'hC305A8;  // Six byte-enable patterns.

  logic        clock;
  logic        reset;
  busRequestT  request;
  logic        ready;
  busResponseT response;
  logic        initBusy;
  sdramPinsT   pins;
  logic [15:0] sdramDataIn;
  int          modelErrors;
  int          refreshCount;
  int          initSteps;

  logic [31:0] shadow [int];
  logic [31:0] expectedQueue [$];
  logic [31:0] expectedRead;
  int          seed;
  int          stimulusErrors = 0;
  int          compareErrors = 0;
  int          acceptCount = 0;
  int          doneCount = 0;
  int          testsPassed = 0;
  int          testsFailed = 0;

  sdramController #(
    .clockInHz(clockInHz)
  ) UUT (
    .clock      (clock),
    .reset      (reset),
    .request    (request),
    .ready      (ready),
    .response   (response),
    .initBusy   (initBusy),
    .pins       (pins),
    .sdramDataIn(sdramDataIn)
  );

  sdramModel #(
    .powerUpCycles(powerUpCycles)
  ) memory (
    .clock         (clock),
    .reset         (reset),
    .pins          (pins),
    .readData      (sdramDataIn),
    .protocolErrors(modelErrors),
    .refreshCount  (refreshCount),
    .initSteps     (initSteps)
  );

  initial clock = 1'b0;
  always #(clockPeriod / 2) clock = ~clock;

  // Write merges into the shadow word and expects zero data back.
  function automatic logic [31:0] expectedWord(input logic readNotWrite,
      input logic [22:0] address, input logic [3:0] byteEnables, input logic [31:0] data);
    logic [31:0] word;
    int          i;
    word = shadow.exists(int'(address)) ? shadow[int'(address)] : 32'h0;
    if (readNotWrite)
      return word;
    for (i = 0; i < 4; i++)
      if (byteEnables[i])
        word[8*i +: 8] = data[8*i +: 8];
    shadow[int'(address)] = word;
    return 32'h0;
  endfunction

  function automatic int totalErrors();
    return stimulusErrors + compareErrors + modelErrors;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stimulusErrors++;
    end
  endtask

  task automatic runRequest(input logic readNotWrite, input logic [22:0] address,
      input logic [3:0] byteEnables, input logic [31:0] data);
    request <= {1'b1, readNotWrite, address, byteEnables, data};
    @(posedge clock);
    while (!ready)
      @(posedge clock);
    request.valid <= 1'b0;  // Accepted on this edge.
    acceptCount++;
    expectedQueue.push_back(expectedWord(readNotWrite, address, byteEnables, data));
    while (doneCount != acceptCount)
      @(posedge clock);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    if (totalErrors() == errorsBefore)
      testsPassed++;
    else
      testsFailed++;
    $display("Test %s finished with %0d errors", name, totalErrors() - errorsBefore);
  endtask

  // Every done pops one expectation.
  always @(posedge clock)
  begin
    if (response.done === 1'b1)
    begin
      if (expectedQueue.size() == 0)
      begin
        $display("At %0t a done arrived with no request outstanding", $time);
        compareErrors++;
      end
      else
      begin
        expectedRead = expectedQueue.pop_front();
        if (response.readData !== expectedRead)
        begin
          $display("CHECK FAILED at %0t: response.readData expected %h, got %h",
                   $time, expectedRead, response.readData);
          compareErrors++;
        end
      end
      doneCount <= doneCount + 1;
    end
  end

  initial
  begin
    #(watchdogCycles * clockPeriod);
    $display("Timeout after %0d cycles, a request or the init never finished", watchdogCycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    int          errorsBefore;
    int          w;
    int          i;
    int          refreshStart;
    int          minimum;
    longint      startTime;
    logic [31:0] randomWord;
    logic [22:0] address;
    seed    = 34427;
    reset   = 1'b1;
    request = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    errorsBefore = totalErrors();
    checkValue("initBusy", 32'd1, 32'(initBusy));
    checkValue("ready", 32'd0, 32'(ready));
    checkValue("response.done", 32'd0, 32'(response.done));
    checkValue("pins.command", 32'(cmdInhibit), 32'(pins.command));
    checkValue("pins.dataDriven", 32'd0, 32'(pins.dataDriven));
    while (initBusy)
      @(posedge clock);
    repeat (3) @(posedge clock);
    checkValue("initSteps", 32'd5, 32'(initSteps));
    reportTest("init sequence", errorsBefore);

    errorsBefore = totalErrors();
    for (w = 0; w < 20; w++)
    begin
      randomWord = $random(seed);
      address    = randomWord[22:0];
      runRequest(1'b0, address, 4'hF, $random(seed));
      runRequest(1'b1, address, 4'h0, 32'h0);
    end
    randomWord = $random(seed);
    runRequest(1'b1, randomWord[22:0], 4'h0, 32'h0);  // Unwritten word.
    reportTest("full write and read", errorsBefore);

    errorsBefore = totalErrors();
    for (w = 0; w < 2; w++)
    begin
      randomWord = $random(seed);
      address    = randomWord[22:0];
      runRequest(1'b0, address, 4'hF, $random(seed));
      for (i = 0; i < 6; i++)
      begin
        runRequest(1'b0, address, enableList[4*i +: 4], $random(seed));
        runRequest(1'b1, address, 4'h0, 32'h0);
      end
    end
    reportTest("partial write", errorsBefore);

    errorsBefore = totalErrors();
    refreshStart = refreshCount;
    startTime    = longint'($time);
    for (w = 0; w < 10; w++)
    begin
      repeat (40) @(posedge clock);
      randomWord = $random(seed);
      address    = randomWord[22:0];
      runRequest(1'b0, address, 4'hF, $random(seed));
      runRequest(1'b1, address, 4'h0, 32'h0);
    end
    minimum = int'((longint'($time) - startTime) / clockPeriod) / refreshPeriodCycles;
    if (refreshCount - refreshStart < minimum)
    begin
      $display("CHECK FAILED at %0t: refreshCount expected at least %0d, got %0d",
               $time, minimum, refreshCount - refreshStart);
      stimulusErrors++;
    end
    reportTest("refresh during traffic", errorsBefore);

    errorsBefore = totalErrors();
    repeat (20) @(posedge clock);
    checkValue("doneCount", 32'(acceptCount), 32'(doneCount));
    checkValue("outstanding requests", 32'd0, 32'(expectedQueue.size()));
    reportTest("every request completes", errorsBefore);

    $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (totalErrors() == 0 && testsFailed == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/sdramPkg.sv
logic/sdramTimer.sv
logic/sdramSequencer.sv
logic/sdramCommandOut.sv
logic/sdramController.sv
test/sdramModel.sv
test/sdramControllerTb.sv

// ==== Makefile ====
SIM = obj_dir/sdramSim

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

$(SIM): all.f $(wildcard logic/*.sv test/*.sv)
	verilator --binary -j 0 --top-module sdramControllerTb -f all.f -Mdir obj_dir -o sdramSim

clean:
	rm -rf obj_dir sim.log
